/* include/demod_params.svh */
/*
 * Demodulated stream back end constants
 * Widths, slice positions and fixed levels shared by every stage
 */

`ifndef DEMOD_PARAMS_SVH
`define DEMOD_PARAMS_SVH

// ============================================================
// Widths
// ============================================================
`define DEMOD_SAMPLE_W    16        // One I or Q sample
`define DEMOD_WORD_W      32        // Packed output word
`define DEMOD_LEN_W       4         // Length code field
`define DEMOD_MODE_W      3         // Processing mode select
`define DEMOD_MOD_W       8         // Modulation type select
`define DEMOD_STATUS_W    4         // Status flag vector
`define DEMOD_ENV_W       32        // Envelope and phase products
`define DEMOD_THR_W       19        // Threshold filter accumulator

// ============================================================
// Length codes per output mode
// ============================================================
`define DEMOD_LEN_IQ      4'd4      // I and Q halves
`define DEMOD_LEN_AUDIO   4'd2      // Audio half only

// Lowest bits taken from the wide products
`define DEMOD_AM_LSB      15        // Envelope bits 30..15
`define DEMOD_FM_LSB      10        // Phase difference bits 25..10

// ============================================================
// FSK slicer levels
// ============================================================
`define DEMOD_FSK_INIT    16'h4000  // Threshold after reset
`define DEMOD_FSK_MARK    16'h7FFF  // Output level above threshold

// Status flag bit positions
`define DEMOD_ST_IQ       0
`define DEMOD_ST_AUDIO    1

`endif

/* run_sim.sh */
#!/bin/sh
# Compile the demodulator stream testbench with Verilator and run it.
# The simulator exit status carries pass or fail.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir

verilator --binary --timing --assert -Wno-fatal \
    --timescale 1ns/100ps \
    -f sources.f \
    --top-module demod_stream_tb \
    -o demod_stream_sim

./obj_dir/demod_stream_sim

/* sources.f */
+incdir+include
verilog/demod_pkg.sv
verilog/mode_decode.sv
verilog/audio_demod.sv
verilog/stream_packer.sv
verilog/demod_stream_top.sv
verification/clock_gen.sv
verification/demod_stream_tb.sv

/* verification/clock_gen.sv */
/*
 * Testbench clock and reset source
 * Free running clock with reset held low for a fixed number of cycles
 */

module clock_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 8
) (
    output logic clk_600m,
    output logic reset_n
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk_600m = 1'b0;
        forever #(PERIOD_NS / 2) clk_600m = ~clk_600m;    // Half period per toggle
    end

    // Released on a rising edge, like a synchronised reset
    initial begin
        reset_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_600m);
        reset_n <= 1'b1;
    end

endmodule

/* verification/demod_stream_tb.sv */
/*
 * Demodulated stream back end testbench
 * LFSR stimulus per mode, rule based reference model, assertion checks
 */

`include "demod_params.svh"

module demod_stream_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int RESET_CYCLES  = 8;
    localparam int PHASE_SAMPLES = 200;
    localparam int NUM_PHASES    = 6;
    localparam int IDLE_GAP      = 4;      // At least 3 so status settles
    // One idle slot in eight on average, doubled for margin
    localparam int TEST_CYCLES    = RESET_CYCLES
                                  + NUM_PHASES * (PHASE_SAMPLES * 9 / 8 + IDLE_GAP + 2);
    localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES + 100;

    logic                    clk_600m;
    logic                    reset_n;
    demod_pkg::iq_sample_t   sample_in;
    logic                    sample_valid;
    logic [2:0]              processing_mode;
    logic [7:0]              modulation_type;
    demod_pkg::stream_word_t stream_out;
    logic [3:0]              status_flags;

    logic [31:0]             lfsr_state = 32'h7e07_cd8e;
    string                   test_name;
    logic                    quiet_window;      // Reset until first phase starts
    int                      words_expected;
    int                      words_seen = 0;
    int                      cycle_count = 0;

    // Reference model state and 3 deep expected pipe
    logic signed [15:0]      ref_prev_i;
    logic signed [15:0]      ref_prev_q;
    logic [15:0]             ref_thr;
    demod_pkg::stream_word_t exp_word [3];
    logic [3:0]              exp_flags [3];
    string                   exp_name [3];

    clock_gen #(.PERIOD_NS(100), .RESET_CYCLES(RESET_CYCLES)) u_clock_gen (
        .clk_600m (clk_600m),
        .reset_n  (reset_n)
    );

    demod_stream_top UUT (
        .clk_600m        (clk_600m),
        .reset_n         (reset_n),
        .sample_in       (sample_in),
        .sample_valid    (sample_valid),
        .processing_mode (processing_mode),
        .modulation_type (modulation_type),
        .stream_out      (stream_out),
        .status_flags    (status_flags)
    );

    // ============================================================
    // Random source
    // ============================================================
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];   // x^32 + x^22 + x^2 + x + 1
        return {s[30:0], fb};
    endfunction

    task automatic draw_bits(input int width, output logic [31:0] value);
        value = '0;
        for (int b = 0; b < width; b++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value      = {value[30:0], lfsr_state[0]};   // One step per bit
        end
    endtask

    // ============================================================
    // Demodulation rules
    // ============================================================
    function automatic logic [15:0] am_audio_of(input logic signed [15:0] i,
                                                input logic signed [15:0] q);
        longint env;
        env = longint'(i) * i + longint'(q) * q;
        return env[30:15];                   // Envelope bits 30..15
    endfunction

    function automatic logic [15:0] fm_audio_of(input logic signed [15:0] i,
                                                input logic signed [15:0] q,
                                                input logic signed [15:0] pi,
                                                input logic signed [15:0] pq);
        longint diff;
        diff = longint'(i) * pq - longint'(q) * pi;
        return diff[25:10];                  // Same bits as the 32 bit wrap
    endfunction

    function automatic logic [15:0] next_threshold(input logic [15:0] thr,
                                                   input logic [15:0] am);
        int sum;
        sum = int'(thr) * 7 + int'(am);      // Below 2^19, no overflow
        return 16'(sum / 8);
    endfunction

    function automatic logic [15:0] select_audio(input logic [7:0] modn,
                                                 input logic [15:0] am,
                                                 input logic [15:0] fm,
                                                 input logic [15:0] fsk);
        case (modn)
            8'd1:    return am;
            8'd2:    return fm;
            8'd3:    return fsk;
            default: return 16'h0000;        // Unknown is silent
        endcase
    endfunction

    function automatic demod_pkg::stream_word_t expected_word(
        input demod_pkg::iq_sample_t s,
        input logic                  v,
        input logic [2:0]            mode,
        input logic [15:0]           audio
    );
        demod_pkg::stream_word_t w;
        w = '0;
        if (v && mode == 3'd1) begin
            w.data  = {s.i, s.q};
            w.len   = `DEMOD_LEN_IQ;
            w.valid = 1'b1;
        end else if (v && mode == 3'd2) begin
            w.data  = {audio, 16'h0000};
            w.len   = `DEMOD_LEN_AUDIO;
            w.valid = 1'b1;
        end
        return w;
    endfunction

    function automatic logic [3:0] expected_flags(input logic [2:0] mode,
                                                  input logic [7:0] modn);
        logic [3:0] f;
        f[0] = (mode == 3'd1);
        f[1] = (mode == 3'd2);
        f[2] = !(modn == 8'd1 || modn == 8'd2 || modn == 8'd3);
        f[3] = (mode > 3'd2);
        return f;
    endfunction

    // ============================================================
    // Reference model
    // ============================================================
    always @(posedge clk_600m or negedge reset_n) begin : ref_model
        logic [15:0] am;
        logic [15:0] audio;
        if (!reset_n) begin
            ref_prev_i <= '0;
            ref_prev_q <= '0;
            ref_thr    <= `DEMOD_FSK_INIT;
            for (int k = 0; k < 3; k++) begin
                exp_word[k]  <= '0;
                exp_flags[k] <= '0;
                exp_name[k]  <= "reset";
            end
        end else begin
            am    = am_audio_of(sample_in.i, sample_in.q);
            audio = select_audio(modulation_type, am,
                                 fm_audio_of(sample_in.i, sample_in.q, ref_prev_i, ref_prev_q),
                                 (am > ref_thr) ? `DEMOD_FSK_MARK : 16'h0000);
            exp_word[0]  <= expected_word(sample_in, sample_valid, processing_mode, audio);
            exp_flags[0] <= expected_flags(processing_mode, modulation_type);
            exp_name[0]  <= test_name;
            for (int k = 1; k < 3; k++) begin
                exp_word[k]  <= exp_word[k-1];
                exp_flags[k] <= exp_flags[k-1];
                exp_name[k]  <= exp_name[k-1];
            end
            if (sample_valid) begin          // History moves in every mode
                ref_prev_i <= sample_in.i;
                ref_prev_q <= sample_in.q;
                ref_thr    <= next_threshold(ref_thr, am);
            end
        end
    end

    // ============================================================
    // Checks, sampled mid cycle
    // ============================================================
    task automatic report_mismatch(input string field, input logic [63:0] expected,
                                   input logic [63:0] actual);
        $display("Error: %s %s expected %0h actual %0h", exp_name[2], field, expected, actual);
        $display("Test failures found");
        $fatal(1, "Output check failed");
    endtask

    reset_check: assert property (@(negedge clk_600m)
        (reset_n && !quiet_window) || (stream_out == '0 && status_flags == '0))
        else report_mismatch("reset outputs", 64'd0, 64'({stream_out, status_flags}));

    valid_check: assert property (@(negedge clk_600m) disable iff (!reset_n)
        stream_out.valid == exp_word[2].valid)
        else report_mismatch("valid", 64'(exp_word[2].valid), 64'(stream_out.valid));

    data_check: assert property (@(negedge clk_600m) disable iff (!reset_n)
        stream_out.data == exp_word[2].data)
        else report_mismatch("data", 64'(exp_word[2].data), 64'(stream_out.data));

    len_check: assert property (@(negedge clk_600m) disable iff (!reset_n)
        stream_out.len == exp_word[2].len)
        else report_mismatch("len", 64'(exp_word[2].len), 64'(stream_out.len));

    flags_check: assert property (@(negedge clk_600m) disable iff (!reset_n)
        status_flags == exp_flags[2])
        else report_mismatch("status_flags", 64'(exp_flags[2]), 64'(status_flags));

    always @(negedge clk_600m) begin
        if (reset_n && stream_out.valid)
            words_seen <= words_seen + 1;    // Cross check against samples sent
    end

    always @(posedge clk_600m) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Test failures found");
            $fatal(1, "Timeout after %0d cycles, stimulus did not finish", cycle_count);
        end
    end

    // ============================================================
    // Stimulus
    // ============================================================
    task automatic run_phase(input string name, input logic [2:0] mode,
                             input logic [7:0] modn, input int count);
        int          sent;
        logic [31:0] gap;
        logic [31:0] ival;
        logic [31:0] qval;
        @(posedge clk_600m);
        sample_valid    <= 1'b0;             // Mode moves only while idle
        processing_mode <= mode;
        modulation_type <= modn;
        test_name       <= name;
        repeat (IDLE_GAP) @(posedge clk_600m);
        sent = 0;
        while (sent < count) begin
            @(posedge clk_600m);
            draw_bits(3, gap);
            if (gap == 0) begin
                sample_valid <= 1'b0;        // Occasional bubble
            end else begin
                draw_bits(16, ival);
                draw_bits(16, qval);
                sample_in.i  <= ival[15:0];
                sample_in.q  <= qval[15:0];
                sample_valid <= 1'b1;
                sent++;
            end
        end
        @(posedge clk_600m);
        sample_valid <= 1'b0;
        if (mode == 3'd1 || mode == 3'd2)
            words_expected += count;
    endtask

    initial begin
        sample_in       = '0;
        sample_valid    = 1'b0;
        processing_mode = 3'd0;
        modulation_type = 8'd1;              // AM keeps status at zero
        test_name       = "reset";
        quiet_window    = 1'b1;
        words_expected  = 0;

        @(posedge clk_600m);
        while (!reset_n) @(posedge clk_600m);
        repeat (IDLE_GAP) @(posedge clk_600m);
        quiet_window = 1'b0;

        run_phase("iq_stream", 3'd1, 8'd1, PHASE_SAMPLES);
        run_phase("am_audio", 3'd2, 8'd1, PHASE_SAMPLES);
        run_phase("fm_audio", 3'd2, 8'd2, PHASE_SAMPLES);
        run_phase("fsk_audio", 3'd2, 8'd3, PHASE_SAMPLES);
        run_phase("unknown_mod", 3'd2, 8'd9, PHASE_SAMPLES);
        run_phase("spectrum_silent", 3'd0, 8'd1, PHASE_SAMPLES / 2);
        run_phase("invalid_mode", 3'd5, 8'd2, PHASE_SAMPLES / 2);

        repeat (IDLE_GAP + 4) @(posedge clk_600m);  // Drain the pipe
        if (words_seen != words_expected) begin
            $display("Error: word_count expected %0d actual %0d", words_expected, words_seen);
            $display("Test failures found");
            $fatal(1, "Stream word count mismatch");
        end else begin
            $display("All tests passed!");
            $finish;
        end
    end

endmodule

/* verilog/audio_demod.sv */
/*
 * AM, FM and FSK demodulator
 * One register stage holding the selected audio alongside the control
 */

`include "demod_params.svh"

module audio_demod (
    input  logic                        clk_600m,
    input  logic                        reset_n,
    input  demod_pkg::demod_ctrl_t      stage_ctrl,
    output demod_pkg::demod_ctrl_t      demod_ctrl_q,
    output logic [`DEMOD_SAMPLE_W-1:0]  audio_sample
);

    logic signed [`DEMOD_SAMPLE_W-1:0] cur_i;
    logic signed [`DEMOD_SAMPLE_W-1:0] cur_q;
    logic signed [`DEMOD_SAMPLE_W-1:0] prev_i;      // Last valid sample
    logic signed [`DEMOD_SAMPLE_W-1:0] prev_q;
    logic signed [`DEMOD_ENV_W-1:0]    i_sq;
    logic signed [`DEMOD_ENV_W-1:0]    q_sq;
    logic signed [`DEMOD_ENV_W-1:0]    i_qprev;
    logic signed [`DEMOD_ENV_W-1:0]    q_iprev;
    logic [`DEMOD_ENV_W-1:0]           am_env;
    logic signed [`DEMOD_ENV_W-1:0]    fm_diff;
    logic [`DEMOD_SAMPLE_W-1:0]        am_audio;
    logic [`DEMOD_SAMPLE_W-1:0]        fm_audio;
    logic [`DEMOD_SAMPLE_W-1:0]        fsk_audio;
    logic [`DEMOD_SAMPLE_W-1:0]        fsk_thr;
    logic [`DEMOD_THR_W-1:0]           thr_sum;
    logic [`DEMOD_SAMPLE_W-1:0]        audio_next;

    assign cur_i = stage_ctrl.sample.i;
    assign cur_q = stage_ctrl.sample.q;

    // ============================================================
    // AM envelope
    // ============================================================
    assign i_sq     = cur_i * cur_i;
    assign q_sq     = cur_q * cur_q;
    assign am_env   = i_sq + q_sq;     // Never above 2^31 so fits unsigned
    assign am_audio = am_env[`DEMOD_AM_LSB +: `DEMOD_SAMPLE_W];

    // ============================================================
    // FM discriminator
    // ============================================================
    assign i_qprev  = cur_i * prev_q;
    assign q_iprev  = cur_q * prev_i;
    assign fm_diff  = i_qprev - q_iprev;   // Wraps at 32 bits
    assign fm_audio = fm_diff[`DEMOD_FM_LSB +: `DEMOD_SAMPLE_W];

    // ============================================================
    // FSK slicer
    // ============================================================

    // Slice against the threshold from before this sample
    assign fsk_audio = (am_audio > fsk_thr) ? `DEMOD_FSK_MARK : '0;

    // Leaky average, 7/8 old plus 1/8 new
    assign thr_sum = fsk_thr * 3'd7 + am_audio;

    // Sample history and threshold move on every valid sample, any mode
    always_ff @(posedge clk_600m or negedge reset_n) begin
        if (!reset_n) begin
            prev_i  <= '0;
            prev_q  <= '0;
            fsk_thr <= `DEMOD_FSK_INIT;
        end else if (stage_ctrl.valid) begin
            prev_i  <= cur_i;
            prev_q  <= cur_q;
            fsk_thr <= thr_sum[`DEMOD_THR_W-1 -: `DEMOD_SAMPLE_W];  // Divide by 8
        end
    end

    // Pick by modulation, unknown gives silence
    always_comb begin
        case (stage_ctrl.modulation)
            demod_pkg::mod_am:  audio_next = am_audio;
            demod_pkg::mod_fm:  audio_next = fm_audio;
            demod_pkg::mod_fsk: audio_next = fsk_audio;
            default:            audio_next = '0;
        endcase
    end

    // ============================================================
    // Output stage
    // ============================================================
    always_ff @(posedge clk_600m or negedge reset_n) begin
        if (!reset_n) begin
            demod_ctrl_q <= '0;
            audio_sample <= '0;
        end else begin
            demod_ctrl_q <= stage_ctrl;      // Control delayed one stage
            audio_sample <= audio_next;
        end
    end

endmodule

/* verilog/demod_pkg.sv */
/*
 * Demodulated stream types
 * Mode and modulation encodings plus the structs passed between stages
 */

`include "demod_params.svh"

package demod_pkg;

    // ============================================================
    // Encodings
    // ============================================================
    typedef enum logic [`DEMOD_MODE_W-1:0] {
        mode_spectrum  = 0,     // FFT path, no output here
        mode_iq_stream = 1,
        mode_audio     = 2
    } proc_mode_e;

    typedef enum logic [`DEMOD_MOD_W-1:0] {
        mod_none = 0,
        mod_am   = 1,           // Square law envelope
        mod_fm   = 2,           // Cross product discriminator
        mod_fsk  = 3            // Envelope vs adaptive threshold
    } modulation_e;

    // ============================================================
    // Structs
    // ============================================================
    typedef struct packed {
        logic signed [`DEMOD_SAMPLE_W-1:0] i;  // Upper half when packed
        logic signed [`DEMOD_SAMPLE_W-1:0] q;
    } iq_sample_t;

    // Control that travels with each sample through the pipe
    typedef struct packed {
        iq_sample_t  sample;
        logic        valid;
        proc_mode_e  mode;
        modulation_e modulation;
        logic        mode_invalid;   // Mode above audio
        logic        mod_unknown;    // Not AM, FM or FSK
    } demod_ctrl_t;

    typedef struct packed {
        logic [`DEMOD_WORD_W-1:0] data;
        logic [`DEMOD_LEN_W-1:0]  len;
        logic                     valid;
    } stream_word_t;

endpackage

/* verilog/demod_stream_top.sv */
/*
 * Demodulated stream back end top level
 * Decode, demodulate and pack, three register stages in a row
 */

`include "demod_params.svh"

module demod_stream_top (
    input  logic                        clk_600m,
    input  logic                        reset_n,
    input  demod_pkg::iq_sample_t       sample_in,
    input  logic                        sample_valid,     // One strobe per sample
    input  logic [`DEMOD_MODE_W-1:0]    processing_mode,
    input  logic [`DEMOD_MOD_W-1:0]     modulation_type,
    output demod_pkg::stream_word_t     stream_out,
    output logic [`DEMOD_STATUS_W-1:0]  status_flags
);

    demod_pkg::demod_ctrl_t     stage_ctrl;    // After decode
    demod_pkg::demod_ctrl_t     demod_ctrl_q;  // After demod
    logic [`DEMOD_SAMPLE_W-1:0] audio_sample;

    // ============================================================
    // Pipeline
    // ============================================================
    mode_decode u_mode_decode (
        .clk_600m        (clk_600m),
        .reset_n         (reset_n),
        .sample_in       (sample_in),
        .sample_valid    (sample_valid),
        .processing_mode (processing_mode),
        .modulation_type (modulation_type),
        .stage_ctrl      (stage_ctrl)
    );

    audio_demod u_audio_demod (
        .clk_600m        (clk_600m),
        .reset_n         (reset_n),
        .stage_ctrl      (stage_ctrl),
        .demod_ctrl_q    (demod_ctrl_q),
        .audio_sample    (audio_sample)
    );

    // Final stage drives the ports directly
    stream_packer u_stream_packer (
        .clk_600m        (clk_600m),
        .reset_n         (reset_n),
        .demod_ctrl_q    (demod_ctrl_q),
        .audio_sample    (audio_sample),
        .stream_out      (stream_out),
        .status_flags    (status_flags)
    );

endmodule

/* verilog/mode_decode.sv */
/*
 * Input register and mode decoder
 * Captures each sample and turns the mode levels into a control struct
 */

`include "demod_params.svh"

module mode_decode (
    input  logic                       clk_600m,
    input  logic                       reset_n,
    input  demod_pkg::iq_sample_t      sample_in,
    input  logic                       sample_valid,
    input  logic [`DEMOD_MODE_W-1:0]   processing_mode,
    input  logic [`DEMOD_MOD_W-1:0]    modulation_type,
    output demod_pkg::demod_ctrl_t     stage_ctrl
);

    demod_pkg::demod_ctrl_t ctrl_next;
    logic                   mode_bad;
    logic                   mod_bad;

    // ============================================================
    // Decode
    // ============================================================

    // Anything past audio has no output path
    assign mode_bad = (processing_mode > demod_pkg::mode_audio);

    // Only the three demodulators are known
    always_comb begin
        case (modulation_type)
            demod_pkg::mod_am,
            demod_pkg::mod_fm,
            demod_pkg::mod_fsk: mod_bad = 1'b0;
            default:            mod_bad = 1'b1;
        endcase
    end

    always_comb begin
        ctrl_next.sample       = sample_in;
        ctrl_next.valid        = sample_valid;
        // Raw values kept even when out of range
        ctrl_next.mode         = demod_pkg::proc_mode_e'(processing_mode);
        ctrl_next.modulation   = demod_pkg::modulation_e'(modulation_type);
        ctrl_next.mode_invalid = mode_bad;
        ctrl_next.mod_unknown  = mod_bad;
    end

    // ============================================================
    // Register stage
    // ============================================================

    // Mode fields load every cycle so status follows idle changes
    always_ff @(posedge clk_600m or negedge reset_n) begin
        if (!reset_n) begin
            stage_ctrl <= '0;
        end else begin
            stage_ctrl <= ctrl_next;
        end
    end

endmodule

/* verilog/stream_packer.sv */
/*
 * Output word packer
 * Builds the streamed word and length per mode and keeps status flags
 */

`include "demod_params.svh"

module stream_packer (
    input  logic                        clk_600m,
    input  logic                        reset_n,
    input  demod_pkg::demod_ctrl_t      demod_ctrl_q,
    input  logic [`DEMOD_SAMPLE_W-1:0]  audio_sample,
    output demod_pkg::stream_word_t     stream_out,
    output logic [`DEMOD_STATUS_W-1:0]  status_flags
);

    demod_pkg::stream_word_t    word_next;
    logic [`DEMOD_STATUS_W-1:0] flags_next;
    logic                       is_iq;
    logic                       is_audio;

    assign is_iq    = (demod_ctrl_q.mode == demod_pkg::mode_iq_stream);
    assign is_audio = (demod_ctrl_q.mode == demod_pkg::mode_audio);

    // ============================================================
    // Word build
    // ============================================================

    // Bus stays all zero unless a sample is present in a live mode
    always_comb begin
        word_next = '0;
        if (demod_ctrl_q.valid) begin
            case (demod_ctrl_q.mode)
                demod_pkg::mode_iq_stream: begin
                    word_next.data  = {demod_ctrl_q.sample.i, demod_ctrl_q.sample.q};
                    word_next.len   = `DEMOD_LEN_IQ;
                    word_next.valid = 1'b1;
                end
                demod_pkg::mode_audio: begin
                    // Audio upper half, lower half zero
                    word_next.data  = {audio_sample, {`DEMOD_SAMPLE_W{1'b0}}};
                    word_next.len   = `DEMOD_LEN_AUDIO;
                    word_next.valid = 1'b1;
                end
                default: begin
                    word_next = '0;        // Spectrum and bad modes are silent
                end
            endcase
        end
    end

    // Flag order is invalid, unknown, audio, I/Q
    always_comb begin
        flags_next                   = '0;
        flags_next[`DEMOD_ST_IQ]     = is_iq;
        flags_next[`DEMOD_ST_AUDIO]  = is_audio;
        flags_next[2]                = demod_ctrl_q.mod_unknown;
        flags_next[3]                = demod_ctrl_q.mode_invalid;
    end

    // ============================================================
    // Register stage
    // ============================================================
    always_ff @(posedge clk_600m or negedge reset_n) begin
        if (!reset_n) begin
            stream_out   <= '0;
            status_flags <= '0;
        end else begin
            stream_out   <= word_next;
            status_flags <= flags_next;      // Every cycle, not just valid
        end
    end

endmodule
